// File: Bender.yml
package:
  name: snes_mem_bridge

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/snes_bridge_pkg.sv
      - rtl/load_sequencer.sv
      - rtl/sdram_request_arbiter.sv
      - rtl/read_data_steer.sv
      - rtl/snes_mem_bridge.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_snes_mem_bridge.sv

// File: rtl/load_sequencer.sv
// cartridge load tracking plus run enable and phase strobes, instantiated once in the bridge top
`default_nettype none
`timescale 1ns/1ns

module load_sequencer
    import snes_bridge_pkg::*;
(
    input  logic      wclk,
    input  logic      resetn,
    input  logic      loading,
    input  logic      loader_do_valid,
    input  logic      sdram_busy,
    input  logic      frame_pause,
    input  logic      sysclkf_ce,
    input  logic      sysclkr_ce,
    output logic      enable,
    output logic      f2,
    output logic      r2,
    output logic      loaded,
    output rom_addr_t loader_addr
);

    // previous loading level for edge detect
    logic loading_r;
    logic load_start;
    logic load_end;

    assign load_start = loading & ~loading_r;
    assign load_end   = ~loading & loading_r;

    // loader byte address and loaded flag
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            loaded      <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            // one step per accepted byte
            if (loader_do_valid) begin
                loader_addr <= loader_addr + 1'b1;
            end
            // new load restarts at zero, wins over the step
            if (load_start) begin
                loader_addr <= '0;
                loaded      <= 1'b0;
            end
            // image complete, core may run
            if (load_end) begin
                loaded <= 1'b1;
            end
        end
    end

    // run enable and phase strobes
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
            f2     <= 1'b0;
            r2     <= 1'b0;
        end else begin
            // hold the core while sdram is busy or video asks for a pause
            enable <= ~sdram_busy & ~frame_pause & loaded;
            // fall and rise phases, only while running
            f2 <= sysclkf_ce & enable;
            r2 <= sysclkr_ce & enable;
        end
    end

endmodule

`default_nettype wire

// File: rtl/read_data_steer.sv
// byte steering of sdram read data back to the core rom, work ram and audio ram ports
`default_nettype none
`timescale 1ns/1ns

module read_data_steer
    import snes_bridge_pkg::*;
(
    input  logic      wclk,
    input  logic      resetn,
    input  rom_bus_t  rom,
    input  logic      wram_addr0,
    input  aram_bus_t aram,
    input  word_t     cpu_port0,
    input  word_t     cpu_port1,
    input  word_t     aram_dout,
    output word_t     rom_q,
    output byte_t     wram_q,
    output byte_t     aram_q
);

    // audio ram byte select, kept from the last read
    logic aram_rd;
    logic aram_lsb;

    assign aram_rd = ~aram.ce_n & ~aram.oe_n;

    // odd byte fetch wants the high byte in the low lane
    assign rom_q = (rom.word | ~rom.addr[0]) ? cpu_port0
                                             : {cpu_port0[7:0], cpu_port0[15:8]};

    // work ram byte by address lsb
    assign wram_q = wram_addr0 ? cpu_port1[15:8] : cpu_port1[7:0];

    // aram data arrives after the read cycle
    // so the lsb has to be held
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            aram_lsb <= 1'b0;
        end else if (aram_rd) begin
            aram_lsb <= aram.addr[0];
        end
    end

    assign aram_q = aram_lsb ? aram_dout[15:8] : aram_dout[7:0];

endmodule

`default_nettype wire

// File: rtl/sdram_request_arbiter.sv
// one-per-cycle sdram cpu port request from loader, rom and work ram, plus save ram strobes
`default_nettype none
`timescale 1ns/1ns

`include "snes_bridge_consts.svh"

module sdram_request_arbiter
    import snes_bridge_pkg::*;
(
    input  logic       wclk,
    input  logic       resetn,
    input  logic       loading,
    input  logic       loader_do_valid,
    input  logic       f2,
    input  logic       r2,
    input  byte_t      loader_do,
    input  rom_addr_t  loader_addr,
    input  rom_bus_t   rom,
    input  wram_bus_t  wram,
    input  bsram_bus_t bsram,
    input  byte_t      rom_type,
    output cpu_req_t   cpu_req,
    output bsram_req_t bsram_req
);

    // decoded strobes from the core buses
    logic wram_rd;
    logic wram_wr;
    logic is_sa1;
    logic bsram_rd_t;
    logic bsram_wr_t;

    // next request, all zero when idle
    cpu_req_t req_d;

    assign wram_rd = ~wram.ce_n & ~wram.rd_n;
    assign wram_wr = ~wram.ce_n & ~wram.we_n;

    // SA-1 reads save ram on every enabled select
    assign is_sa1 = (rom_type[7:4] == `MAP_SA1);

    assign bsram_rd_t = ~bsram.ce_n & (~bsram.rd_n | is_sa1) & f2;
    assign bsram_wr_t = ~bsram.ce_n & ~bsram.we_n & r2;

    always_comb begin
        req_d = '0;
        if (loading & loader_do_valid) begin
            // loader byte on both lanes
            // even address takes the low lane
            req_d.wr   = 1'b1;
            req_d.addr = loader_addr[`SDRAM_AW-1:0];
            req_d.ds   = {loader_addr[0], ~loader_addr[0]};
            req_d.din  = {loader_do, loader_do};
        end else if (~rom.ce_n & ~bsram_rd_t & f2) begin
            // rom fetch in the fall phase
            // full word, steering happens on the way back
            req_d.rd   = 1'b1;
            req_d.addr = rom.addr[`SDRAM_AW-1:0];
            req_d.ds   = 2'b11;
        end else if ((wram_rd & f2) | (wram_wr & r2)) begin
            // work ram through port 1
            req_d.port = 1'b1;
            req_d.addr = {`WRAM_BASE, wram.addr};
            req_d.ds   = {wram.addr[0], ~wram.addr[0]};
            req_d.din  = {wram.data, wram.data};
            // read in f2, write in r2
            req_d.rd   = wram_rd & f2;
            req_d.wr   = wram_wr & r2;
        end
    end

    // cpu port request, one cycle wide
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_req <= '0;
        end else begin
            cpu_req <= req_d;
        end
    end

    // save ram request
    // address and data follow the bus every cycle
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bsram_req <= '0;
        end else begin
            bsram_req.rd   <= bsram_rd_t;
            bsram_req.wr   <= bsram_wr_t;
            bsram_req.addr <= bsram.addr;
            bsram_req.din  <= bsram.data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/snes_bridge_consts.svh
// bus widths and fixed codes of the memory bridge, included by the package and the arbiter
`ifndef SNES_BRIDGE_CONSTS_SVH
`define SNES_BRIDGE_CONSTS_SVH

// sdram byte address, 8 MB
`define SDRAM_AW 23

// rom bus address as seen by the core
`define ROM_AW 24

// work ram, 128 KB
`define WRAM_AW 17

// save ram, up to 1 MB
`define BSRAM_AW 20

// audio ram, 64 KB
`define ARAM_AW 16

// top prefix of the sdram for work ram
// banks 7E and 7F land at the last 128 KB
`define WRAM_BASE 6'b111111

// upper nibble of rom_type for SA-1 carts
`define MAP_SA1 4'hC

`endif

// File: rtl/snes_bridge_pkg.sv
// shared vector types and bus bundles for the memory bridge, imported by the rtl and the testbench
`default_nettype none

`include "snes_bridge_consts.svh"

package snes_bridge_pkg;

    // plain data widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // address widths
    typedef logic [`SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [`ROM_AW-1:0]   rom_addr_t;
    typedef logic [`WRAM_AW-1:0]  wram_addr_t;
    typedef logic [`BSRAM_AW-1:0] bsram_addr_t;
    typedef logic [`ARAM_AW-1:0]  aram_addr_t;

    // core rom side, word set means a 16-bit fetch
    typedef struct packed {
        logic      ce_n;
        logic      word;
        rom_addr_t addr;
    } rom_bus_t;

    // core work ram side, strobes active low
    typedef struct packed {
        logic       ce_n;
        logic       rd_n;
        logic       we_n;
        wram_addr_t addr;
        byte_t      data;
    } wram_bus_t;

    // core save ram side
    typedef struct packed {
        logic        ce_n;
        logic        rd_n;
        logic        we_n;
        bsram_addr_t addr;
        byte_t       data;
    } bsram_bus_t;

    // core audio ram side, read path only
    typedef struct packed {
        logic       ce_n;
        logic       oe_n;
        aram_addr_t addr;
    } aram_bus_t;

    // one request on the sdram cpu port
    // port 0 is rom and loader, port 1 is work ram
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic        port;
        logic [1:0]  ds;
        sdram_addr_t addr;
        word_t       din;
    } cpu_req_t;

    // registered save ram request
    typedef struct packed {
        logic        rd;
        logic        wr;
        bsram_addr_t addr;
        byte_t       din;
    } bsram_req_t;

endpackage

`default_nettype wire

// File: rtl/snes_mem_bridge.sv
// memory bridge top between the console core and sdram, wiring sequencer, arbiter and steering
`default_nettype none
`timescale 1ns/1ns

module snes_mem_bridge
    import snes_bridge_pkg::*;
(
    input  logic       wclk,
    input  logic       resetn,
    // core side
    input  rom_bus_t   rom,
    input  wram_bus_t  wram,
    input  bsram_bus_t bsram,
    input  aram_bus_t  aram,
    input  logic       sysclkf_ce,
    input  logic       sysclkr_ce,
    input  byte_t      rom_type,
    // loader
    input  logic       loading,
    input  byte_t      loader_do,
    input  logic       loader_do_valid,
    // memory side
    input  logic       sdram_busy,
    input  word_t      cpu_port0,
    input  word_t      cpu_port1,
    input  word_t      aram_dout,
    // video side
    input  logic       frame_pause,
    // outputs
    output cpu_req_t   cpu_req,
    output bsram_req_t bsram_req,
    output logic       enable,
    output logic       loaded,
    output word_t      rom_q,
    output byte_t      wram_q,
    output byte_t      aram_q
);

    // phase strobes and loader address
    logic      f2;
    logic      r2;
    rom_addr_t loader_addr;

    load_sequencer i_load_sequencer (
        .wclk            (wclk),
        .resetn          (resetn),
        .loading         (loading),
        .loader_do_valid (loader_do_valid),
        .sdram_busy      (sdram_busy),
        .frame_pause     (frame_pause),
        .sysclkf_ce      (sysclkf_ce),
        .sysclkr_ce      (sysclkr_ce),
        .enable          (enable),
        .f2              (f2),
        .r2              (r2),
        .loaded          (loaded),
        .loader_addr     (loader_addr)
    );

    sdram_request_arbiter i_sdram_request_arbiter (
        .wclk            (wclk),
        .resetn          (resetn),
        .loading         (loading),
        .loader_do_valid (loader_do_valid),
        .f2              (f2),
        .r2              (r2),
        .loader_do       (loader_do),
        .loader_addr     (loader_addr),
        .rom             (rom),
        .wram            (wram),
        .bsram           (bsram),
        .rom_type        (rom_type),
        .cpu_req         (cpu_req),
        .bsram_req       (bsram_req)
    );

    // wram byte select from the live address
    read_data_steer i_read_data_steer (
        .wclk       (wclk),
        .resetn     (resetn),
        .rom        (rom),
        .wram_addr0 (wram.addr[0]),
        .aram       (aram),
        .cpu_port0  (cpu_port0),
        .cpu_port1  (cpu_port1),
        .aram_dout  (aram_dout),
        .rom_q      (rom_q),
        .wram_q     (wram_q),
        .aram_q     (aram_q)
    );

endmodule

`default_nettype wire

// File: snes_mem_bridge.f
+incdir+rtl
+incdir+verif
rtl/snes_bridge_pkg.sv
rtl/load_sequencer.sv
rtl/sdram_request_arbiter.sv
rtl/read_data_steer.sv
rtl/snes_mem_bridge.sv
verif/tb_snes_mem_bridge.sv

// File: verif/tb_vectors.svh
// stimulus and expected-value table for the bridge testbench, included inside its top module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one table row, held for cycles clocks, checked at the last falling edge
// sel bits: 8 aram rd, 7 rom word, 6 rom, 5 wram rd, 4 wram wr, 3 bs ce, 2 bs rd, 1 bs wr, 0 sa1
typedef struct {
    logic        ld;
    logic        vld;
    byte_t       dout;
    logic        busy;
    logic        pause;
    logic        fce;
    logic        rce;
    logic [8:0]  sel;
    rom_addr_t   addr;
    int unsigned cycles;
    cpu_req_t    exp_req;
    logic [1:0]  exp_bs;
    logic        exp_en;
    logic        exp_ld;
} vec_t;

localparam int NV = 38;

// exp_req is {rd wr port ds, addr, din}, exp_bs is {rd, wr}
vec_t vectors [NV] = '{
    // reset state, then three loader bytes
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 0, 0},
    '{1, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 0, 0},
    '{1, 1, 8'hA1, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 0, 0},
    '{1, 1, 8'hB2, 0, 0, 0, 0, 9'h000, 24'h000000, 1, {5'h09, 23'h000000, 16'hA1A1}, 2'b00, 0, 0},
    '{1, 1, 8'hC3, 0, 0, 0, 0, 9'h000, 24'h000000, 1, {5'h0A, 23'h000001, 16'hB2B2}, 2'b00, 0, 0},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, {5'h09, 23'h000002, 16'hC3C3}, 2'b00, 0, 0},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 0, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 1, 1},
    // rom read two cycles after the fall strobe
    '{0, 0, 8'h00, 0, 0, 1, 0, 9'h140, 24'h012345, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h040, 24'h012345, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h140, 24'h012345, 1, {5'h13, 23'h012345, 16'h0000}, 2'b00, 1, 1},
    // busy and pause hold the core
    '{0, 0, 8'h00, 1, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 1, 0, 9'h0C0, 24'h012346, 1, 44'h0, 2'b00, 0, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h0C0, 24'h012347, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 1, 0, 0, 9'h000, 24'h000000, 2, 44'h0, 2'b00, 0, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 2, 44'h0, 2'b00, 1, 1},
    // work ram read in f2, write in r2
    '{0, 0, 8'h00, 0, 0, 1, 0, 9'h020, 24'h000003, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h020, 24'h000003, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h020, 24'h000003, 1, {5'h16, 23'h7E0003, 16'h0000}, 2'b00, 1, 1},
    '{0, 0, 8'h5A, 0, 0, 0, 1, 9'h010, 24'h000010, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h5A, 0, 0, 0, 0, 9'h010, 24'h000010, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, {5'h0D, 23'h7E0010, 16'h5A5A}, 2'b00, 1, 1},
    // loader byte beats a work ram read in the same cycle
    '{1, 0, 8'h00, 0, 0, 1, 0, 9'h020, 24'h000005, 1, 44'h0, 2'b00, 1, 1},
    '{1, 1, 8'h77, 0, 0, 0, 0, 9'h020, 24'h000005, 1, 44'h0, 2'b00, 1, 0},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, {5'h09, 23'h000000, 16'h7777}, 2'b00, 0, 0},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 2, 44'h0, 2'b00, 1, 1},
    // save ram read blocks rom, then SA-1 select alone, then write
    '{0, 0, 8'h00, 0, 0, 1, 0, 9'h04C, 24'h000100, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h04C, 24'h000100, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h100, 24'h000100, 1, 44'h0, 2'b10, 1, 1},
    '{0, 0, 8'h00, 0, 0, 1, 0, 9'h049, 24'h000101, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h049, 24'h000101, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b10, 1, 1},
    '{0, 0, 8'h3C, 0, 0, 0, 1, 9'h00A, 24'h000200, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h3C, 0, 0, 0, 0, 9'h00A, 24'h000200, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b01, 1, 1},
    // odd audio ram read, then idle to see the held byte select
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h100, 24'h000007, 1, 44'h0, 2'b00, 1, 1},
    '{0, 0, 8'h00, 0, 0, 0, 0, 9'h000, 24'h000000, 1, 44'h0, 2'b00, 1, 1}
};

`endif

// File: verif/tb_snes_mem_bridge.sv
// testbench for the memory bridge top, runs the vector table and checks every row
`default_nettype none
`timescale 1ns/1ns

module tb_snes_mem_bridge
    import snes_bridge_pkg::*;
();

    `include "tb_vectors.svh"

    logic       wclk;
    logic       resetn;
    rom_bus_t   rom;
    wram_bus_t  wram;
    bsram_bus_t bsram;
    aram_bus_t  aram;
    logic       sysclkf_ce;
    logic       sysclkr_ce;
    byte_t      rom_type;
    logic       loading;
    byte_t      loader_do;
    logic       loader_do_valid;
    logic       sdram_busy;
    word_t      cpu_port0;
    word_t      cpu_port1;
    word_t      aram_dout;
    logic       frame_pause;
    cpu_req_t   cpu_req;
    bsram_req_t bsram_req;
    logic       enable;
    logic       loaded;
    word_t      rom_q;
    byte_t      wram_q;
    byte_t      aram_q;

    // copies of the random read data for the expected bytes
    word_t p0_w;
    word_t p1_w;
    word_t ad_w;
    // audio ram byte select as the bridge should hold it
    logic  lsb_m;
    // save ram address and data as registered from the bus
    bsram_addr_t bs_addr_m;
    byte_t       bs_din_m;

    snes_mem_bridge i_snes_mem_bridge (.*);

    always #10 wclk = ~wclk;

    task automatic report_mismatch(input string sig, input int row,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("MISMATCH %s row %0d got %h expected %h", sig, row, got, exp);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // inputs of one row, applied after a rising edge
    task automatic apply_row(input vec_t v);
        p0_w = word_t'($urandom);
        p1_w = word_t'($urandom);
        ad_w = word_t'($urandom);
        cpu_port0       <= p0_w;
        cpu_port1       <= p1_w;
        aram_dout       <= ad_w;
        loading         <= v.ld;
        loader_do_valid <= v.vld;
        loader_do       <= v.dout;
        sdram_busy      <= v.busy;
        frame_pause     <= v.pause;
        sysclkf_ce      <= v.fce;
        sysclkr_ce      <= v.rce;
        rom      <= {~v.sel[6], v.sel[7], v.addr};
        wram     <= {~(v.sel[5] | v.sel[4]), ~v.sel[5], ~v.sel[4], v.addr[16:0], v.dout};
        bsram    <= {~v.sel[3], ~v.sel[2], ~v.sel[1], v.addr[19:0], v.dout};
        aram     <= {~v.sel[8], ~v.sel[8], v.addr[15:0]};
        rom_type <= v.sel[0] ? 8'hC0 : 8'h20;
    endtask

    task automatic check_row(input vec_t v, input int row);
        word_t rom_exp;
        byte_t wram_exp;
        byte_t aram_exp;
        // byte-wide odd rom fetch swaps the lanes
        rom_exp  = (v.sel[7] || !v.addr[0]) ? p0_w : {p0_w[7:0], p0_w[15:8]};
        wram_exp = v.addr[0] ? p1_w[15:8] : p1_w[7:0];
        // a held row has already latched its own audio address
        if (v.cycles > 1 && v.sel[8]) begin
            lsb_m = v.addr[0];
        end
        // a held row has already registered its own save ram bus
        if (v.cycles > 1) begin
            bs_addr_m = v.addr[19:0];
            bs_din_m  = v.dout;
        end
        aram_exp = lsb_m ? ad_w[15:8] : ad_w[7:0];
        assert (cpu_req === v.exp_req)
            else report_mismatch("cpu_req", row, 64'(cpu_req), 64'(v.exp_req));
        assert ({bsram_req.rd, bsram_req.wr} === v.exp_bs)
            else report_mismatch("bsram_req.rd/wr", row,
                                 64'({bsram_req.rd, bsram_req.wr}), 64'(v.exp_bs));
        assert (bsram_req.addr === bs_addr_m)
            else report_mismatch("bsram_req.addr", row,
                                 64'(bsram_req.addr), 64'(bs_addr_m));
        assert (bsram_req.din === bs_din_m)
            else report_mismatch("bsram_req.din", row,
                                 64'(bsram_req.din), 64'(bs_din_m));
        assert (enable === v.exp_en)
            else report_mismatch("enable", row, 64'(enable), 64'(v.exp_en));
        assert (loaded === v.exp_ld)
            else report_mismatch("loaded", row, 64'(loaded), 64'(v.exp_ld));
        assert (rom_q === rom_exp)
            else report_mismatch("rom_q", row, 64'(rom_q), 64'(rom_exp));
        assert (wram_q === wram_exp)
            else report_mismatch("wram_q", row, 64'(wram_q), 64'(wram_exp));
        assert (aram_q === aram_exp)
            else report_mismatch("aram_q", row, 64'(aram_q), 64'(aram_exp));
        if (v.sel[8]) begin
            lsb_m = v.addr[0];
        end
        // next edge registers this row's save ram bus
        bs_addr_m = v.addr[19:0];
        bs_din_m  = v.dout;
    endtask

    initial begin
        wclk            = 1'b0;
        resetn          = 1'b0;
        rom             = {1'b1, 1'b0, 24'h0};
        wram            = {3'b111, 25'h0};
        bsram           = {3'b111, 28'h0};
        aram            = {2'b11, 16'h0};
        sysclkf_ce      = 1'b0;
        sysclkr_ce      = 1'b0;
        rom_type        = 8'h20;
        loading         = 1'b0;
        loader_do       = 8'h00;
        loader_do_valid = 1'b0;
        sdram_busy      = 1'b0;
        cpu_port0       = 16'h0;
        cpu_port1       = 16'h0;
        aram_dout       = 16'h0;
        frame_pause     = 1'b0;
        lsb_m           = 1'b0;
        bs_addr_m       = '0;
        bs_din_m        = 8'h00;
        void'($urandom(32'had0e_d06e));
        repeat (3) @(posedge wclk);
        resetn <= 1'b1;
        for (int i = 0; i < NV; i++) begin
            @(posedge wclk);
            apply_row(vectors[i]);
            repeat (vectors[i].cycles - 1) @(posedge wclk);
            @(negedge wclk);
            check_row(vectors[i], i);
        end
        $display("** PASS **");
        $finish;
    end

    // rows times the longest hold plus reset and slack
    initial begin
        int unsigned max_hold;
        max_hold = 1;
        foreach (vectors[k]) begin
            if (vectors[k].cycles > max_hold) begin
                max_hold = vectors[k].cycles;
            end
        end
        #((NV * max_hold + 20) * 20);
        $display("timeout, the vector table did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

endmodule

`default_nettype wire
